//--- src/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// datapath and register file widths.
`define XLEN        32
`define REG_ADDR_W  5

// rv32i major opcodes handled by this slice.
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_BRANCH  7'b1100011

`endif

//--- src/rv_pkg.sv
`include "rv_defs.svh"

package rv_pkg;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_ctrl_t;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU
    } branch_t;

    typedef enum logic [1:0] {
        JMP_NONE,
        JMP_JAL,
        JMP_JALR
    } jump_t;

    typedef enum logic [1:0] {
        UP_NONE,
        UP_LUI,
        UP_AUIPC
    } upper_t;

    typedef logic [1:0] result_src_t;   // 00 alu, 10 pc+4, 11 upper.
    typedef logic [2:0] mem_op_t;       // funct3 of a load or store.

endpackage

//--- src/control_decoder.sv
`timescale 1ns/100ps
`include "rv_defs.svh"

module control_decoder import rv_pkg::*; (
    input  logic        valid_i,
    input  word_t       instr_i,
    output logic        reg_write_o,
    output result_src_t result_src_o,
    output logic        mem_write_o,
    output jump_t       jump_o,
    output branch_t     branch_o,
    output alu_ctrl_t   alu_control_o,
    output logic        alu_src_o,
    output upper_t      upper_op_o,
    output mem_op_t     memory_op_o,
    output reg_addr_t   rs1_o,
    output reg_addr_t   rs2_o,
    output reg_addr_t   rd_o,
    output word_t       imm_ext_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;    // instr bit 30, sub / sra.

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign alt    = instr_i[30];

    function automatic alu_ctrl_t alu_fn(input logic [2:0] f3, input logic sub_sra);
        case (f3)
            3'b000:  alu_fn = sub_sra ? ALU_SUB : ALU_ADD;
            3'b001:  alu_fn = ALU_SLL;
            3'b010:  alu_fn = ALU_SLT;
            3'b011:  alu_fn = ALU_SLTU;
            3'b100:  alu_fn = ALU_XOR;
            3'b101:  alu_fn = sub_sra ? ALU_SRA : ALU_SRL;
            3'b110:  alu_fn = ALU_OR;
            default: alu_fn = ALU_AND;
        endcase
    endfunction

    always_comb begin
        // bubble unless a supported opcode overrides.
        reg_write_o   = 1'b0;
        result_src_o  = '0;
        mem_write_o   = 1'b0;
        jump_o        = JMP_NONE;
        branch_o      = BR_NONE;
        alu_control_o = ALU_ADD;
        alu_src_o     = 1'b0;
        upper_op_o    = UP_NONE;
        memory_op_o   = '0;
        imm_ext_o     = '0;
        if (valid_i) begin
            case (opcode)
                `OPC_OP: begin
                    reg_write_o   = 1'b1;
                    alu_control_o = alu_fn(funct3, alt);
                end
                `OPC_OP_IMM: begin
                    reg_write_o   = 1'b1;
                    alu_src_o     = 1'b1;
                    alu_control_o = alu_fn(funct3, alt && funct3 == 3'b101); // no subi.
                    imm_ext_o     = {{20{instr_i[31]}}, instr_i[31:20]};
                end
                `OPC_LUI, `OPC_AUIPC: begin
                    reg_write_o  = 1'b1;
                    result_src_o = 2'b11;
                    upper_op_o   = (opcode == `OPC_LUI) ? UP_LUI : UP_AUIPC;
                    imm_ext_o    = {instr_i[31:12], 12'b0};
                end
                `OPC_JAL: begin
                    reg_write_o  = 1'b1;
                    result_src_o = 2'b10;
                    jump_o       = JMP_JAL;
                    imm_ext_o    = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                                    instr_i[30:21], 1'b0};
                end
                `OPC_JALR: begin
                    reg_write_o  = 1'b1;
                    result_src_o = 2'b10;
                    jump_o       = JMP_JALR;
                    alu_src_o    = 1'b1;    // rs1 + imm target.
                    imm_ext_o    = {{20{instr_i[31]}}, instr_i[31:20]};
                end
                `OPC_BRANCH: begin
                    case (funct3)
                        3'b000:  branch_o = BR_EQ;
                        3'b001:  branch_o = BR_NE;
                        3'b100:  branch_o = BR_LT;
                        3'b101:  branch_o = BR_GE;
                        3'b110:  branch_o = BR_LTU;
                        3'b111:  branch_o = BR_GEU;
                        default: branch_o = BR_NONE;
                    endcase
                    imm_ext_o = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                                 instr_i[11:8], 1'b0};
                end
                default: ;
            endcase
        end
    end

    // register fields pass only for instructions that do something.
    always_comb begin
        if (reg_write_o || branch_o != BR_NONE) begin
            rs1_o = instr_i[19:15];
            rs2_o = instr_i[24:20];
            rd_o  = instr_i[11:7];
        end else begin
            rs1_o = '0;
            rs2_o = '0;
            rd_o  = '0;
        end
    end

endmodule

//--- src/register_file.sv
`timescale 1ns/100ps
`include "rv_defs.svh"

module register_file import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst_i,
    input  logic      we_i,
    input  reg_addr_t waddr_i,
    input  word_t     wdata_i,
    input  reg_addr_t raddr1_i,
    input  reg_addr_t raddr2_i,
    output word_t     rdata1_o,
    output word_t     rdata2_o
);

    word_t regs [1:(1 << `REG_ADDR_W) - 1];   // x0 not stored.

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 1; i < (1 << `REG_ADDR_W); i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // write-first, so decode sees the value retiring this cycle.
    assign rdata1_o = (raddr1_i == '0)              ? '0      :
                      (we_i && waddr_i == raddr1_i) ? wdata_i : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0)              ? '0      :
                      (we_i && waddr_i == raddr2_i) ? wdata_i : regs[raddr2_i];

endmodule

//--- src/decode_pipeline_regfile.sv
`timescale 1ns/100ps

module decode_pipeline_regfile import rv_pkg::*; (
    input  logic        clk,
    input  logic        rst_i,
    input  logic        en_i,
    input  logic        clear_i,

    input  logic        reg_write_i,
    input  result_src_t result_src_i,
    input  logic        mem_write_i,
    input  jump_t       jump_i,
    input  branch_t     branch_i,
    input  alu_ctrl_t   alu_control_i,
    input  logic        alu_src_i,
    input  upper_t      upper_op_i,
    input  mem_op_t     memory_op_i,
    input  word_t       rd1_i,
    input  word_t       rd2_i,
    input  word_t       pc_i,
    input  reg_addr_t   rs1_i,
    input  reg_addr_t   rs2_i,
    input  reg_addr_t   rd_i,
    input  word_t       imm_ext_i,
    input  word_t       pc_plus4_i,

    output logic        reg_write_o,
    output result_src_t result_src_o,
    output logic        mem_write_o,
    output jump_t       jump_o,
    output branch_t     branch_o,
    output alu_ctrl_t   alu_control_o,
    output logic        alu_src_o,
    output upper_t      upper_op_o,
    output mem_op_t     memory_op_o,
    output word_t       rd1_o,
    output word_t       rd2_o,
    output word_t       pc_o,
    output reg_addr_t   rs1_o,
    output reg_addr_t   rs2_o,
    output reg_addr_t   rd_o,
    output word_t       imm_ext_o,
    output word_t       pc_plus4_o
);

    always_ff @(posedge clk) begin
        if (rst_i || clear_i) begin    // flush to a bubble, over any stall.
            reg_write_o   <= 1'b0;
            result_src_o  <= '0;
            mem_write_o   <= 1'b0;
            jump_o        <= JMP_NONE;
            branch_o      <= BR_NONE;
            alu_control_o <= ALU_ADD;
            alu_src_o     <= 1'b0;
            upper_op_o    <= UP_NONE;
            memory_op_o   <= '0;
            rd1_o         <= '0;
            rd2_o         <= '0;
            pc_o          <= '0;
            rs1_o         <= '0;
            rs2_o         <= '0;
            rd_o          <= '0;
            imm_ext_o     <= '0;
            pc_plus4_o    <= '0;
        end else if (en_i) begin
            reg_write_o   <= reg_write_i;
            result_src_o  <= result_src_i;
            mem_write_o   <= mem_write_i;
            jump_o        <= jump_i;
            branch_o      <= branch_i;
            alu_control_o <= alu_control_i;
            alu_src_o     <= alu_src_i;
            upper_op_o    <= upper_op_i;
            memory_op_o   <= memory_op_i;
            rd1_o         <= rd1_i;
            rd2_o         <= rd2_i;
            pc_o          <= pc_i;
            rs1_o         <= rs1_i;
            rs2_o         <= rs2_i;
            rd_o          <= rd_i;
            imm_ext_o     <= imm_ext_i;
            pc_plus4_o    <= pc_plus4_i;
        end
    end

endmodule

//--- src/execute_unit.sv
`timescale 1ns/100ps

module execute_unit import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst_i,
    input  logic      hold_i,
    input  logic      reg_write_i,
    input  jump_t     jump_i,
    input  branch_t   branch_i,
    input  alu_ctrl_t alu_control_i,
    input  logic      alu_src_i,
    input  upper_t    upper_op_i,
    input  word_t     rd1_i,
    input  word_t     rd2_i,
    input  word_t     pc_i,
    input  reg_addr_t rs1_i,
    input  reg_addr_t rs2_i,
    input  reg_addr_t rd_i,
    input  word_t     imm_ext_i,
    input  word_t     pc_plus4_i,
    output logic      redirect_o,
    output word_t     redirect_pc_o,
    output logic      wb_we_o,
    output reg_addr_t wb_rd_o,
    output word_t     wb_data_o
);

    logic  fwd_vld_q;   // wb_rd/wb_data hold a real result.
    logic  taken;
    logic  wr_en;
    word_t src_a;
    word_t src_b;
    word_t alu_b;
    word_t alu_y;
    word_t pc_imm;
    word_t result;

    assign src_a = (fwd_vld_q && wb_rd_o == rs1_i) ? wb_data_o : rd1_i;
    assign src_b = (fwd_vld_q && wb_rd_o == rs2_i) ? wb_data_o : rd2_i;
    assign alu_b = alu_src_i ? imm_ext_i : src_b;
    assign pc_imm = pc_i + imm_ext_i;

    always_comb begin
        case (alu_control_i)
            ALU_SUB:  alu_y = src_a - alu_b;
            ALU_SLL:  alu_y = src_a << alu_b[4:0];
            ALU_SLT:  alu_y = word_t'($signed(src_a) < $signed(alu_b));
            ALU_SLTU: alu_y = word_t'(src_a < alu_b);
            ALU_XOR:  alu_y = src_a ^ alu_b;
            ALU_SRL:  alu_y = src_a >> alu_b[4:0];
            ALU_SRA:  alu_y = word_t'($signed(src_a) >>> alu_b[4:0]);
            ALU_OR:   alu_y = src_a | alu_b;
            ALU_AND:  alu_y = src_a & alu_b;
            default:  alu_y = src_a + alu_b;
        endcase
    end

    always_comb begin
        case (branch_i)
            BR_EQ:   taken = src_a == src_b;
            BR_NE:   taken = src_a != src_b;
            BR_LT:   taken = $signed(src_a) < $signed(src_b);
            BR_GE:   taken = $signed(src_a) >= $signed(src_b);
            BR_LTU:  taken = src_a < src_b;
            BR_GEU:  taken = src_a >= src_b;
            default: taken = 1'b0;
        endcase
    end

    // no redirect while stalled, it fires once the hold drops.
    assign redirect_o    = (taken || jump_i != JMP_NONE) && !hold_i;
    assign redirect_pc_o = (jump_i == JMP_JALR) ? {alu_y[31:1], 1'b0} : pc_imm;

    always_comb begin
        if (jump_i != JMP_NONE)
            result = pc_plus4_i;
        else if (upper_op_i == UP_LUI)
            result = imm_ext_i;
        else if (upper_op_i == UP_AUIPC)
            result = pc_imm;
        else
            result = alu_y;
    end

    assign wr_en = reg_write_i && rd_i != '0;   // x0 writes dropped here.

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wb_we_o   <= 1'b0;
            fwd_vld_q <= 1'b0;
        end else if (hold_i) begin
            wb_we_o   <= 1'b0;  // bubble, last result stays for forwarding.
        end else begin
            wb_we_o   <= wr_en;
            fwd_vld_q <= wr_en;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_i) begin
            wb_rd_o   <= rd_i;
            wb_data_o <= result;
        end
    end

endmodule

//--- src/decode_execute_core.sv
`timescale 1ns/100ps

module decode_execute_core import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst_i,
    input  logic      valid_i,
    input  logic      hold_i,
    input  word_t     instr_i,
    input  word_t     pc_i,
    output logic      redirect_o,
    output word_t     redirect_pc_o,
    output logic      wb_we_o,
    output reg_addr_t wb_rd_o,
    output word_t     wb_data_o
);

    // decode stage.
    logic        d_reg_write;
    result_src_t d_result_src;
    logic        d_mem_write;
    jump_t       d_jump;
    branch_t     d_branch;
    alu_ctrl_t   d_alu_control;
    logic        d_alu_src;
    upper_t      d_upper_op;
    mem_op_t     d_memory_op;
    reg_addr_t   d_rs1;
    reg_addr_t   d_rs2;
    reg_addr_t   d_rd;
    word_t       d_imm_ext;
    word_t       d_rd1;
    word_t       d_rd2;

    // execute stage.
    logic        e_reg_write;
    jump_t       e_jump;
    branch_t     e_branch;
    alu_ctrl_t   e_alu_control;
    logic        e_alu_src;
    upper_t      e_upper_op;
    word_t       e_rd1;
    word_t       e_rd2;
    word_t       e_pc;
    reg_addr_t   e_rs1;
    reg_addr_t   e_rs2;
    reg_addr_t   e_rd;
    word_t       e_imm_ext;
    word_t       e_pc_plus4;

    control_decoder control_decoder_i (
        .valid_i       (valid_i),
        .instr_i       (instr_i),
        .reg_write_o   (d_reg_write),
        .result_src_o  (d_result_src),
        .mem_write_o   (d_mem_write),
        .jump_o        (d_jump),
        .branch_o      (d_branch),
        .alu_control_o (d_alu_control),
        .alu_src_o     (d_alu_src),
        .upper_op_o    (d_upper_op),
        .memory_op_o   (d_memory_op),
        .rs1_o         (d_rs1),
        .rs2_o         (d_rs2),
        .rd_o          (d_rd),
        .imm_ext_o     (d_imm_ext)
    );

    register_file register_file_i (
        .clk      (clk),
        .rst_i    (rst_i),
        .we_i     (wb_we_o),
        .waddr_i  (wb_rd_o),
        .wdata_i  (wb_data_o),
        .raddr1_i (d_rs1),
        .raddr2_i (d_rs2),
        .rdata1_o (d_rd1),
        .rdata2_o (d_rd2)
    );

    decode_pipeline_regfile decode_pipeline_regfile_i (
        .clk           (clk),
        .rst_i         (rst_i),
        .en_i          (~hold_i),
        .clear_i       (redirect_o | rst_i),  // drop the wrong-path instruction.
        .reg_write_i   (d_reg_write),
        .result_src_i  (d_result_src),
        .mem_write_i   (d_mem_write),
        .jump_i        (d_jump),
        .branch_i      (d_branch),
        .alu_control_i (d_alu_control),
        .alu_src_i     (d_alu_src),
        .upper_op_i    (d_upper_op),
        .memory_op_i   (d_memory_op),
        .rd1_i         (d_rd1),
        .rd2_i         (d_rd2),
        .pc_i          (pc_i),
        .rs1_i         (d_rs1),
        .rs2_i         (d_rs2),
        .rd_i          (d_rd),
        .imm_ext_i     (d_imm_ext),
        .pc_plus4_i    (pc_i + word_t'(4)),
        .reg_write_o   (e_reg_write),
        .result_src_o  (),                    // for the memory stage.
        .mem_write_o   (),
        .jump_o        (e_jump),
        .branch_o      (e_branch),
        .alu_control_o (e_alu_control),
        .alu_src_o     (e_alu_src),
        .upper_op_o    (e_upper_op),
        .memory_op_o   (),
        .rd1_o         (e_rd1),
        .rd2_o         (e_rd2),
        .pc_o          (e_pc),
        .rs1_o         (e_rs1),
        .rs2_o         (e_rs2),
        .rd_o          (e_rd),
        .imm_ext_o     (e_imm_ext),
        .pc_plus4_o    (e_pc_plus4)
    );

    execute_unit execute_unit_i (
        .clk           (clk),
        .rst_i         (rst_i),
        .hold_i        (hold_i),
        .reg_write_i   (e_reg_write),
        .jump_i        (e_jump),
        .branch_i      (e_branch),
        .alu_control_i (e_alu_control),
        .alu_src_i     (e_alu_src),
        .upper_op_i    (e_upper_op),
        .rd1_i         (e_rd1),
        .rd2_i         (e_rd2),
        .pc_i          (e_pc),
        .rs1_i         (e_rs1),
        .rs2_i         (e_rs2),
        .rd_i          (e_rd),
        .imm_ext_i     (e_imm_ext),
        .pc_plus4_i    (e_pc_plus4),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o),
        .wb_we_o       (wb_we_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o)
    );

endmodule

//--- test/decode_execute_assertions.sv
`timescale 1ns/100ps

module decode_execute_assertions import rv_pkg::*; (
    input logic      clk,
    input logic      rst_i,
    input logic      hold_i,
    input logic      redirect_o,
    input logic      wb_we_o,
    input reg_addr_t wb_rd_o
);

    no_redirect_in_hold: assert property (
        @(posedge clk) disable iff (rst_i) hold_i |-> !redirect_o
    ) else $error("redirect raised while the pipeline is held");

    // flushed slot must retire as a bubble.
    flushed_slot_silent: assert property (
        @(posedge clk) disable iff (rst_i) redirect_o |-> ##2 !wb_we_o
    ) else $error("instruction behind a redirect wrote back");

    no_x0_write: assert property (
        @(posedge clk) disable iff (rst_i) wb_we_o |-> wb_rd_o != '0
    ) else $error("writeback targets x0");

endmodule

bind decode_execute_core decode_execute_assertions decode_execute_assertions_i (
    .clk        (clk),
    .rst_i      (rst_i),
    .hold_i     (hold_i),
    .redirect_o (redirect_o),
    .wb_we_o    (wb_we_o),
    .wb_rd_o    (wb_rd_o)
);

//--- test/decode_execute_tb.sv
`timescale 1ns/100ps
`include "rv_defs.svh"

module decode_execute_tb import rv_pkg::*; ();

    localparam int N_INSTR        = 400;
    localparam int RESET_CYCLES   = 8;
    localparam int TIMEOUT_CYCLES = N_INSTR * 4 + RESET_CYCLES;

    logic      clk = 1'b0;
    logic      rst_i;
    logic      valid_i;
    logic      hold_i;
    word_t     instr_i;
    word_t     pc_i;
    logic      redirect_o;
    word_t     redirect_pc_o;
    logic      wb_we_o;
    reg_addr_t wb_rd_o;
    word_t     wb_data_o;

    logic [31:0] lfsr_state = 32'h6245;
    word_t       ref_regs [32];
    reg_addr_t   exp_rd_q [$];
    word_t       exp_data_q [$];
    logic        exp_redirect = 1'b0;
    word_t       exp_target = '0;
    reg_addr_t   want_rd;
    word_t       want_data;
    int          cycle_count = 0;

    // fetch side model.
    word_t     pc;
    word_t     target_pc;
    logic      squash;      // redirect pending, next edge flushes.
    logic      held;
    int        accepted;
    logic      ref_wr;
    reg_addr_t ref_rd;
    word_t     ref_data;
    logic      ref_redir;
    word_t     ref_tgt;

    decode_execute_core decode_execute_core_i (
        .clk           (clk),
        .rst_i         (rst_i),
        .valid_i       (valid_i),
        .hold_i        (hold_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o),
        .wb_we_o       (wb_we_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o)
    );

    always #2 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1.
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // random instruction on x0..x7, so dependencies are frequent.
    function automatic word_t make_instr();
        logic [2:0]  kind;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic        alt;
        logic [11:0] imm;
        word_t       upper;
        word_t       off;
        kind  = 3'(rand_bits(3));
        f3    = 3'(rand_bits(3));
        rd    = 5'(rand_bits(3));
        rs1   = 5'(rand_bits(3));
        rs2   = 5'(rand_bits(3));
        alt   = (rand_bits(1) != 0) && (f3 == 3'd0 || f3 == 3'd5);
        imm   = 12'(rand_bits(12));
        upper = rand_bits(20);
        off   = {{20{imm[9]}}, imm[9:0], 2'b00};
        case (kind)
            3'd0, 3'd1: return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, `OPC_OP};
            3'd2, 3'd3: begin
                if (f3 == 3'd1 || f3 == 3'd5)
                    imm = {1'b0, alt && f3 == 3'd5, 5'b0, imm[4:0]};  // shamt form.
                return {imm, rs1, f3, rd, `OPC_OP_IMM};
            end
            3'd4: return {upper[19:0], rd, `OPC_LUI};
            3'd5: return {upper[19:0], rd, `OPC_AUIPC};
            3'd6: begin
                if (f3 == 3'd2 || f3 == 3'd3)
                    f3 = f3 ^ 3'd6;
                return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OPC_BRANCH};
            end
            default: begin
                if (imm[11])
                    return {imm, rs1, 3'b000, rd, `OPC_JALR};
                return {off[20], off[10:1], off[11], off[19:12], rd, `OPC_JAL};
            end
        endcase
    endfunction

    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t x, input word_t y);
        case (f3)
            3'd0: return alt ? x - y : x + y;
            3'd1: return x << y[4:0];
            3'd2: return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            3'd3: return (x < y) ? 32'd1 : 32'd0;
            3'd4: return x ^ y;
            3'd5: begin
                if (alt)
                    return $signed(x) >>> y[4:0];
                return x >> y[4:0];
            end
            3'd6: return x | y;
            default: return x & y;
        endcase
    endfunction

    // architectural result of one instruction on ref_regs.
    function automatic void ref_execute(input word_t instr, input word_t at_pc,
                                        output logic wr, output reg_addr_t rd,
                                        output word_t data, output logic redir,
                                        output word_t target);
        logic [2:0] f3;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        word_t      imm_u;
        word_t      imm_b;
        word_t      imm_j;
        f3     = instr[14:12];
        a      = ref_regs[instr[19:15]];
        b      = ref_regs[instr[24:20]];
        imm_i  = {{20{instr[31]}}, instr[31:20]};
        imm_u  = {instr[31:12], 12'b0};
        imm_b  = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        imm_j  = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
        rd     = instr[11:7];
        wr     = 1'b1;
        redir  = 1'b0;
        data   = at_pc + 32'd4;
        target = '0;
        case (instr[6:0])
            `OPC_OP:     data = alu_ref(f3, instr[30], a, b);
            `OPC_OP_IMM: data = alu_ref(f3, instr[30] && f3 == 3'd5, a, imm_i);
            `OPC_LUI:    data = imm_u;
            `OPC_AUIPC:  data = at_pc + imm_u;
            `OPC_JAL: begin
                redir  = 1'b1;
                target = at_pc + imm_j;
            end
            `OPC_JALR: begin
                redir  = 1'b1;
                target = (a + imm_i) & ~32'd1;
            end
            default: begin   // conditional branch.
                wr     = 1'b0;
                target = at_pc + imm_b;
                case (f3)
                    3'd0:    redir = a == b;
                    3'd1:    redir = a != b;
                    3'd4:    redir = $signed(a) < $signed(b);
                    3'd5:    redir = $signed(a) >= $signed(b);
                    3'd6:    redir = a < b;
                    default: redir = a >= b;
                endcase
            end
        endcase
        if (rd == '0)
            wr = 1'b0;
    endfunction

    initial begin
        rst_i     = 1'b1;
        valid_i   = 1'b0;
        hold_i    = 1'b0;
        instr_i   = '0;
        pc_i      = '0;
        pc        = 32'h0000_0100;
        target_pc = '0;
        squash    = 1'b0;
        held      = 1'b0;
        accepted  = 0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        while (accepted < N_INSTR) begin
            @(negedge clk);
            if (!held) begin                 // inputs stay put under hold.
                valid_i = (rand_bits(2) != 0);
                instr_i = valid_i ? make_instr() : '0;
                pc_i    = pc;
            end
            held         = (rand_bits(3) == 0);
            hold_i       = held;
            exp_redirect = squash && !held;
            exp_target   = target_pc;
            if (!held) begin
                if (squash) begin
                    squash = 1'b0;           // presented word is flushed.
                    pc     = target_pc;
                end else if (valid_i) begin
                    ref_execute(instr_i, pc, ref_wr, ref_rd, ref_data, ref_redir, ref_tgt);
                    if (ref_wr) begin
                        exp_rd_q.push_back(ref_rd);
                        exp_data_q.push_back(ref_data);
                        ref_regs[ref_rd] = ref_data;
                    end
                    squash    = ref_redir;
                    target_pc = ref_tgt;
                    pc        = pc + 32'd4;
                    accepted++;
                end
            end
        end
        repeat (4) begin
            @(negedge clk);
            valid_i      = 1'b0;
            hold_i       = 1'b0;
            exp_redirect = squash;
            exp_target   = target_pc;
            squash       = 1'b0;
        end
        @(negedge clk);
        if (exp_rd_q.size() == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            fail_run($sformatf("%0d expected writebacks never appeared", exp_rd_q.size()));
        end
    end

    always @(posedge clk) begin
        if (!rst_i) begin
            assert (redirect_o == exp_redirect)
                else fail_run($sformatf("Fail at %0t: redirect_o got %b expected %b",
                                        $time, redirect_o, exp_redirect));
            if (exp_redirect) begin
                assert (redirect_pc_o == exp_target)
                    else fail_run($sformatf("Fail at %0t: redirect_pc_o got %h expected %h",
                                            $time, redirect_pc_o, exp_target));
            end
            if (wb_we_o) begin
                assert (exp_rd_q.size() > 0)
                    else fail_run("a writeback appeared with no instruction waiting to retire");
                want_rd   = exp_rd_q.pop_front();
                want_data = exp_data_q.pop_front();
                assert (wb_rd_o == want_rd)
                    else fail_run($sformatf("Fail at %0t: wb_rd_o got %0d expected %0d",
                                            $time, wb_rd_o, want_rd));
                assert (wb_data_o == want_data)
                    else fail_run($sformatf("Fail at %0t: wb_data_o got %h expected %h",
                                            $time, wb_data_o, want_data));
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES)
            fail_run("timeout, the instruction stream did not finish in time");
    end

endmodule

//--- list.f
+incdir+src
src/rv_pkg.sv
src/control_decoder.sv
src/register_file.sv
src/decode_pipeline_regfile.sv
src/execute_unit.sv
src/decode_execute_core.sv
test/decode_execute_assertions.sv
test/decode_execute_tb.sv

//--- Bender.yml
package:
  name: decode_execute

sources:
  - include_dirs:
      - src
    files:
      - src/rv_pkg.sv
      - src/control_decoder.sv
      - src/register_file.sv
      - src/decode_pipeline_regfile.sv
      - src/execute_unit.sv
      - src/decode_execute_core.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/decode_execute_assertions.sv
      - test/decode_execute_tb.sv
